//--- verilog/battle_pkg.sv
package battle_pkg;

    //////////////////////////////////////////////////
    // game scenes, driven by the scene controller
    //////////////////////////////////////////////////
    typedef enum logic [3:0] {
        scene_start  = 4'd1,
        scene_choose = 4'd2,
        scene_fight  = 4'd3,
        scene_win    = 4'd4
    } scene_t;

    // fight states, numbered as the display side expects
    typedef enum logic [5:0] {
        fight_menu           = 6'd1,
        fight_choosing_skill = 6'd2,
        fight_animation_p1   = 6'd3,
        fight_animation_p2   = 6'd4,
        fight_draining_p1    = 6'd5,
        fight_draining_p2    = 6'd6,
        fight_p1_win         = 6'd7,
        fight_p2_win         = 6'd8
    } fight_state_t;

    // main menu: 1 fight, 2 flee
    // skill menu: 1 to 3 skills, 4 back
    typedef enum logic [3:0] {
        option_1 = 4'd1,
        option_2 = 4'd2,
        option_3 = 4'd3,
        option_4 = 4'd4
    } option_t;

    // packed as up, down, left, right, confirm
    typedef logic [4:0] keys_t;

    localparam keys_t key_up      = 5'b10000;
    localparam keys_t key_down    = 5'b01000;
    localparam keys_t key_left    = 5'b00100;
    localparam keys_t key_right   = 5'b00010;
    localparam keys_t key_confirm = 5'b00001;

endpackage

//--- verilog/creature_pkg.sv
package creature_pkg;

    //////////////////////////////////////////////////
    // per-creature data
    //////////////////////////////////////////////////
    typedef logic [7:0] hp_t;
    typedef logic [7:0] stat_t;
    typedef logic [7:0] damage_t;

    // same width as the menu option, so a confirmed option latches as is
    typedef logic [3:0] skill_id_t;

    // skills per creature
    localparam int skill_count = 3;

endpackage

//--- verilog/interval_timer.sv
module interval_timer #(
    parameter int length = 16
) (
    input  logic clk,
    input  logic reset,
    input  logic start,
    output logic done
);

    localparam int count_w = $clog2(length + 1);

    logic [count_w-1:0] count;
    logic               fired;

    // counts only while start is held
    // one done per run, then waits for start to drop
    always_ff @(posedge clk) begin
        if (reset || !start) begin
            count <= '0;
            fired <= 1'b0;
            done  <= 1'b0;
        end else if (fired) begin
            done <= 1'b0;
        end else if (count == count_w'(length - 1)) begin
            fired <= 1'b1;
            done  <= 1'b1;
        end else begin
            count <= count + 1'b1;
        end
    end

endmodule

//--- verilog/menu_cursor.sv
module menu_cursor (
    input  logic                     clk,
    input  logic                     reset,
    input  battle_pkg::keys_t        keys,
    input  battle_pkg::fight_state_t fight_state,
    input  logic                     restart,
    input  logic                     running,
    output battle_pkg::option_t      option
);

    battle_pkg::option_t next_option;

    //////////////////////////////////////////////////
    // cursor moves
    //////////////////////////////////////////////////
    always_comb begin
        next_option = option;
        case (fight_state)
            battle_pkg::fight_menu: begin
                case (option)
                    battle_pkg::option_1: begin
                        if (keys == battle_pkg::key_right) next_option = battle_pkg::option_2;
                    end
                    battle_pkg::option_2: begin
                        if (keys == battle_pkg::key_left) next_option = battle_pkg::option_1;
                    end
                    // left over from the skill menu
                    default: next_option = battle_pkg::option_1;
                endcase
            end
            battle_pkg::fight_choosing_skill: begin
                // 2x2 grid: 1 2 on top, 3 4 below
                if (keys == battle_pkg::key_confirm) begin
                    next_option = battle_pkg::option_1;
                end else begin
                    case (option)
                        battle_pkg::option_1: begin
                            if (keys == battle_pkg::key_down) next_option = battle_pkg::option_3;
                            if (keys == battle_pkg::key_right) next_option = battle_pkg::option_2;
                        end
                        battle_pkg::option_2: begin
                            if (keys == battle_pkg::key_down) next_option = battle_pkg::option_4;
                            if (keys == battle_pkg::key_left) next_option = battle_pkg::option_1;
                        end
                        battle_pkg::option_3: begin
                            if (keys == battle_pkg::key_up) next_option = battle_pkg::option_1;
                            if (keys == battle_pkg::key_right) next_option = battle_pkg::option_4;
                        end
                        default: begin
                            if (keys == battle_pkg::key_up) next_option = battle_pkg::option_2;
                            if (keys == battle_pkg::key_left) next_option = battle_pkg::option_3;
                        end
                    endcase
                end
            end
            // attacks and wins park the cursor
            default: next_option = battle_pkg::option_1;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset || restart) begin
            option <= battle_pkg::option_1;
        end else if (running) begin
            option <= next_option;
        end
    end

    // once settled in the fight scene the main menu sits on fight or flee
    assert property (@(posedge clk) disable iff (reset)
        running && $past(running) && fight_state == battle_pkg::fight_menu
            |-> option inside {battle_pkg::option_1, battle_pkg::option_2});

endmodule

//--- verilog/skill_select.sv
module skill_select (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    commit,
    input  battle_pkg::option_t     option,
    input  creature_pkg::damage_t   p1_damage_1,
    input  creature_pkg::damage_t   p1_damage_2,
    input  creature_pkg::damage_t   p1_damage_3,
    input  creature_pkg::damage_t   p2_damage_1,
    input  creature_pkg::damage_t   p2_damage_2,
    input  creature_pkg::damage_t   p2_damage_3,
    output creature_pkg::skill_id_t p1_skill_id,
    output creature_pkg::skill_id_t p2_skill_id,
    output creature_pkg::damage_t   p1_damage_sel,
    output creature_pkg::damage_t   p2_damage_sel
);

    localparam creature_pkg::skill_id_t last_skill =
        creature_pkg::skill_id_t'(creature_pkg::skill_count);

    creature_pkg::skill_id_t rotation;

    function automatic creature_pkg::damage_t pick_damage(
        input creature_pkg::skill_id_t id,
        input creature_pkg::damage_t   d1,
        input creature_pkg::damage_t   d2,
        input creature_pkg::damage_t   d3
    );
        case (id)
            4'd1:    return d1;
            4'd2:    return d2;
            4'd3:    return d3;
            default: return '0;
        endcase
    endfunction

    // opponent choice, steps 1 2 3 1 ...
    always_ff @(posedge clk) begin
        if (reset || rotation == last_skill) begin
            rotation <= 4'd1;
        end else begin
            rotation <= rotation + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            p1_skill_id <= 4'd1;
            p2_skill_id <= 4'd1;
        end else if (commit) begin
            p1_skill_id <= creature_pkg::skill_id_t'(option);
            p2_skill_id <= rotation;
        end
    end

    // valid in the commit cycle, before the ids latch
    assign p1_damage_sel = pick_damage(creature_pkg::skill_id_t'(option),
                                       p1_damage_1, p1_damage_2, p1_damage_3);
    assign p2_damage_sel = pick_damage(rotation, p2_damage_1, p2_damage_2, p2_damage_3);

    assert property (@(posedge clk) disable iff (reset)
        p2_skill_id inside {[4'd1 : last_skill]});

endmodule

//--- verilog/hp_drain.sv
module hp_drain #(
    parameter int tick_cycles = 5_000_000
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  restart,
    input  creature_pkg::hp_t     hp_init,
    input  logic                  commit,
    input  creature_pkg::damage_t damage,
    input  logic                  drain,
    input  logic                  running,
    output creature_pkg::hp_t     hp,
    output logic                  at_target,
    output logic                  empty
);

    creature_pkg::hp_t target;
    logic              tick_start;
    logic              tick_done;

    interval_timer #(
        .length(tick_cycles)
    ) u_tick (
        .clk  (clk),
        .reset(reset),
        .start(tick_start),
        .done (tick_done)
    );

    assign at_target = (hp == target);
    assign empty     = (hp == '0);

    // drop start for a cycle after each tick so the timer reruns
    always_ff @(posedge clk) begin
        if (reset) begin
            tick_start <= 1'b0;
        end else begin
            tick_start <= drain && running && !tick_done && !at_target;
        end
    end

    //////////////////////////////////////////////////
    // hit points and drain target
    //////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (reset || restart) begin
            hp     <= hp_init;
            target <= hp_init;
        end else begin
            if (commit) begin
                // saturate, a big hit ends at zero
                target <= (hp >= damage) ? hp - damage : '0;
            end
            if (drain && running && tick_done && !at_target) begin
                hp <= hp - 1'b1;
            end
        end
    end

    assert property (@(posedge clk) disable iff (reset || restart)
        !$past(reset) && !$past(restart) |-> hp <= $past(hp));

endmodule

//--- verilog/turn_sequencer.sv
module turn_sequencer #(
    parameter int anim_cycles = 300_000_000,
    parameter int end_cycles  = 300_000_000
) (
    input  logic                     clk,
    input  logic                     reset,
    input  battle_pkg::scene_t       scene,
    input  battle_pkg::keys_t        keys,
    input  battle_pkg::option_t      option,
    input  creature_pkg::stat_t      p1_speed,
    input  creature_pkg::stat_t      p2_speed,
    input  logic                     p1_at_target,
    input  logic                     p2_at_target,
    input  logic                     p1_empty,
    input  logic                     p2_empty,
    output battle_pkg::fight_state_t fight_state,
    output logic                     commit,
    output logic                     restart,
    output logic                     running,
    output logic                     drain_p1,
    output logic                     drain_p2,
    output logic                     to_end_scene
);

    battle_pkg::fight_state_t next_state;
    logic p1_first;
    logic in_anim, in_win;
    logic anim_start, anim_done;
    logic end_start, end_done, end_fired;

    interval_timer #(.length(anim_cycles)) u_anim_timer (
        .clk(clk), .reset(reset), .start(anim_start), .done(anim_done)
    );

    interval_timer #(.length(end_cycles)) u_end_timer (
        .clk(clk), .reset(reset), .start(end_start), .done(end_done)
    );

    assign running  = (scene == battle_pkg::scene_fight);
    assign restart  = (scene == battle_pkg::scene_choose);
    assign p1_first = (p1_speed >= p2_speed);
    assign in_anim  = fight_state inside {battle_pkg::fight_animation_p1,
                                          battle_pkg::fight_animation_p2};
    assign in_win   = fight_state inside {battle_pkg::fight_p1_win, battle_pkg::fight_p2_win};
    assign drain_p1 = running && fight_state == battle_pkg::fight_draining_p1;
    assign drain_p2 = running && fight_state == battle_pkg::fight_draining_p2;
    assign commit   = running && fight_state == battle_pkg::fight_choosing_skill
                      && keys == battle_pkg::key_confirm && option != battle_pkg::option_4;

    //////////////////////////////////////////////////
    // fight FSM
    //////////////////////////////////////////////////
    always_comb begin
        next_state = fight_state;
        case (fight_state)
            battle_pkg::fight_menu: begin
                if (keys == battle_pkg::key_confirm) begin
                    if (option == battle_pkg::option_1) next_state = battle_pkg::fight_choosing_skill;
                    if (option == battle_pkg::option_2) next_state = battle_pkg::fight_p2_win;
                end
            end
            battle_pkg::fight_choosing_skill: begin
                if (option == battle_pkg::option_4 && keys == battle_pkg::key_confirm) begin
                    next_state = battle_pkg::fight_menu;
                end else if (commit) begin
                    next_state = p1_first ? battle_pkg::fight_animation_p1
                                          : battle_pkg::fight_animation_p2;
                end
            end
            // the attacker's animation leads to the defender's drain
            battle_pkg::fight_animation_p1: begin
                if (anim_done) next_state = battle_pkg::fight_draining_p2;
            end
            battle_pkg::fight_animation_p2: begin
                if (anim_done) next_state = battle_pkg::fight_draining_p1;
            end
            battle_pkg::fight_draining_p1: begin
                if (p1_at_target) begin
                    if (p1_empty) next_state = battle_pkg::fight_p2_win;
                    else next_state = p1_first ? battle_pkg::fight_menu
                                               : battle_pkg::fight_animation_p1;
                end
            end
            battle_pkg::fight_draining_p2: begin
                if (p2_at_target) begin
                    if (p2_empty) next_state = battle_pkg::fight_p1_win;
                    else next_state = p1_first ? battle_pkg::fight_animation_p2
                                               : battle_pkg::fight_menu;
                end
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            fight_state  <= battle_pkg::fight_menu;
            anim_start   <= 1'b0;
            end_start    <= 1'b0;
            end_fired    <= 1'b0;
            to_end_scene <= 1'b0;
        end else begin
            // frozen to menu outside the fight scene
            fight_state  <= running ? next_state : battle_pkg::fight_menu;
            anim_start   <= running && in_anim && !anim_done;
            // ending timer runs once per win
            end_start    <= running && in_win && !end_done && !end_fired;
            end_fired    <= in_win && (end_fired || end_done);
            to_end_scene <= end_done;
        end
    end

    assert property (@(posedge clk) disable iff (reset) !(drain_p1 && drain_p2));

endmodule

//--- verilog/battle_control.sv
module battle_control #(
    parameter int anim_cycles = 300_000_000,
    parameter int tick_cycles = 5_000_000,
    parameter int end_cycles  = 300_000_000
) (
    input  logic                     clk,
    input  logic                     reset,
    input  battle_pkg::scene_t       scene,
    input  battle_pkg::keys_t        keys,
    input  creature_pkg::hp_t        p1_hp_init,
    input  creature_pkg::hp_t        p2_hp_init,
    input  creature_pkg::stat_t      p1_speed,
    input  creature_pkg::stat_t      p2_speed,
    input  creature_pkg::damage_t    p1_damage_1,
    input  creature_pkg::damage_t    p1_damage_2,
    input  creature_pkg::damage_t    p1_damage_3,
    input  creature_pkg::damage_t    p2_damage_1,
    input  creature_pkg::damage_t    p2_damage_2,
    input  creature_pkg::damage_t    p2_damage_3,
    output creature_pkg::hp_t        p1_hp,
    output creature_pkg::hp_t        p2_hp,
    output creature_pkg::skill_id_t  p1_skill_id,
    output creature_pkg::skill_id_t  p2_skill_id,
    output battle_pkg::fight_state_t fight_state,
    output battle_pkg::option_t      option,
    output logic                     to_end_scene
);

    logic commit, restart, running;
    logic drain_p1, drain_p2;
    logic p1_at_target, p2_at_target, p1_empty, p2_empty;
    creature_pkg::damage_t p1_damage_sel, p2_damage_sel;

    turn_sequencer #(.anim_cycles(anim_cycles), .end_cycles(end_cycles)) u_turn_sequencer (
        .clk(clk), .reset(reset), .scene(scene), .keys(keys), .option(option),
        .p1_speed(p1_speed), .p2_speed(p2_speed),
        .p1_at_target(p1_at_target), .p2_at_target(p2_at_target),
        .p1_empty(p1_empty), .p2_empty(p2_empty),
        .fight_state(fight_state), .commit(commit), .restart(restart), .running(running),
        .drain_p1(drain_p1), .drain_p2(drain_p2), .to_end_scene(to_end_scene)
    );

    menu_cursor u_menu_cursor (
        .clk(clk), .reset(reset), .keys(keys), .fight_state(fight_state),
        .restart(restart), .running(running), .option(option)
    );

    skill_select u_skill_select (
        .clk(clk), .reset(reset), .commit(commit), .option(option),
        .p1_damage_1(p1_damage_1), .p1_damage_2(p1_damage_2), .p1_damage_3(p1_damage_3),
        .p2_damage_1(p2_damage_1), .p2_damage_2(p2_damage_2), .p2_damage_3(p2_damage_3),
        .p1_skill_id(p1_skill_id), .p2_skill_id(p2_skill_id),
        .p1_damage_sel(p1_damage_sel), .p2_damage_sel(p2_damage_sel)
    );

    // each creature is drained by the other's selected damage
    hp_drain #(.tick_cycles(tick_cycles)) u_p1_drain (
        .clk(clk), .reset(reset), .restart(restart), .hp_init(p1_hp_init),
        .commit(commit), .damage(p2_damage_sel), .drain(drain_p1), .running(running),
        .hp(p1_hp), .at_target(p1_at_target), .empty(p1_empty)
    );

    hp_drain #(.tick_cycles(tick_cycles)) u_p2_drain (
        .clk(clk), .reset(reset), .restart(restart), .hp_init(p2_hp_init),
        .commit(commit), .damage(p1_damage_sel), .drain(drain_p2), .running(running),
        .hp(p2_hp), .at_target(p2_at_target), .empty(p2_empty)
    );

endmodule

//--- sim/tb_battle_control.sv
module tb_battle_control;

    timeunit 1ns;
    timeprecision 1ps;

    logic clk = 1'b0;
    logic reset;
    logic to_end_scene;
    battle_pkg::scene_t scene;
    battle_pkg::keys_t keys;
    battle_pkg::fight_state_t fight_state;
    battle_pkg::option_t option;
    creature_pkg::hp_t p1_hp_init, p2_hp_init, p1_hp, p2_hp;
    creature_pkg::stat_t p1_speed, p2_speed;
    creature_pkg::damage_t p1_damage_1, p1_damage_2, p1_damage_3;
    creature_pkg::damage_t p2_damage_1, p2_damage_2, p2_damage_3;
    creature_pkg::skill_id_t p1_skill_id, p2_skill_id;
    int seed = 32'hbb3d;

    battle_control #(.anim_cycles(6), .tick_cycles(2), .end_cycles(10)) u_battle_control (.*);

    always #4 clk = ~clk;

    //////////////////////////////////////////////////
    // error reporting and compares
    //////////////////////////////////////////////////
    task automatic stop_run(input string what);
        $display("%s", what);
        $display("RESULT: FAIL");
        $fatal(1, "stopping at first error");
    endtask

    task automatic report_mismatch(input string test, input int expected, input int actual);
        stop_run($sformatf("Mismatch in %s: expected %0d, actual %0d", test, expected, actual));
    endtask

    task automatic check_state(input string test, input battle_pkg::fight_state_t expected,
                               input battle_pkg::fight_state_t actual);
        if (actual !== expected) report_mismatch(test, int'(expected), int'(actual));
    endtask

    task automatic check_option(input string test, input battle_pkg::option_t expected,
                                input battle_pkg::option_t actual);
        if (actual !== expected) report_mismatch(test, int'(expected), int'(actual));
    endtask

    task automatic check_hp(input string test, input creature_pkg::hp_t expected,
                            input creature_pkg::hp_t actual);
        if (actual !== expected) report_mismatch(test, int'(expected), int'(actual));
    endtask

    task automatic check_skill(input string test, input creature_pkg::skill_id_t expected,
                               input creature_pkg::skill_id_t actual);
        if (actual !== expected) report_mismatch(test, int'(expected), int'(actual));
    endtask

    // expected hp after a hit, floored at zero
    function automatic creature_pkg::hp_t after_hit(input creature_pkg::hp_t hp,
                                                    input creature_pkg::damage_t dmg);
        int left;
        left = int'(hp) - int'(dmg);
        return (left < 0) ? '0 : creature_pkg::hp_t'(left);
    endfunction

    //////////////////////////////////////////////////
    // stimulus helpers, all on the falling edge
    //////////////////////////////////////////////////
    task automatic press(input battle_pkg::keys_t k);
        keys = k;
        @(negedge clk);
        keys = '0;
    endtask

    task automatic randomize_creatures(input creature_pkg::stat_t s1, input creature_pkg::stat_t s2);
        p1_speed    = s1;
        p2_speed    = s2;
        p1_hp_init  = creature_pkg::hp_t'(100 + ($random(seed) & 63));
        p2_hp_init  = creature_pkg::hp_t'(100 + ($random(seed) & 63));
        p1_damage_1 = creature_pkg::damage_t'(1 + ($random(seed) & 15));
        p1_damage_2 = creature_pkg::damage_t'(1 + ($random(seed) & 15));
        p1_damage_3 = creature_pkg::damage_t'(1 + ($random(seed) & 15));
        p2_damage_1 = creature_pkg::damage_t'(1 + ($random(seed) & 15));
        p2_damage_2 = creature_pkg::damage_t'(1 + ($random(seed) & 15));
        p2_damage_3 = creature_pkg::damage_t'(1 + ($random(seed) & 15));
    endtask

    // through the choose scene and back, hp reloads
    task automatic reload;
        scene = battle_pkg::scene_choose;
        repeat (2) @(negedge clk);
        scene = battle_pkg::scene_fight;
        @(negedge clk);
    endtask

    // runs until menu or a win, noting the animation order
    task automatic wait_exchange(input string test, output battle_pkg::fight_state_t first_anim,
                                 output battle_pkg::fight_state_t last_anim);
        int cycles;
        cycles     = 0;
        first_anim = battle_pkg::fight_menu;
        last_anim  = battle_pkg::fight_menu;
        while (!(fight_state inside {battle_pkg::fight_menu, battle_pkg::fight_p1_win,
                                     battle_pkg::fight_p2_win})) begin
            if (fight_state inside {battle_pkg::fight_animation_p1,
                                    battle_pkg::fight_animation_p2}) begin
                if (first_anim == battle_pkg::fight_menu) first_anim = fight_state;
                last_anim = fight_state;
            end
            if (cycles == 2000) stop_run({test, ": the exchange never ended"});
            cycles++;
            @(negedge clk);
        end
    endtask

    task automatic run_exchange(input string test, input int k,
                                input battle_pkg::fight_state_t first);
        creature_pkg::hp_t hp1;
        creature_pkg::hp_t hp2;
        creature_pkg::damage_t d1 [1:3];
        creature_pkg::damage_t d2 [1:3];
        battle_pkg::fight_state_t first_anim, last_anim;
        hp1 = p1_hp_init;
        hp2 = p2_hp_init;
        d1  = '{p1_damage_1, p1_damage_2, p1_damage_3};
        d2  = '{p2_damage_1, p2_damage_2, p2_damage_3};
        press(battle_pkg::key_confirm);
        check_state(test, battle_pkg::fight_choosing_skill, fight_state);
        if (k == 2) press(battle_pkg::key_right);
        if (k == 3) press(battle_pkg::key_down);
        check_option(test, battle_pkg::option_t'(k), option);
        press(battle_pkg::key_confirm);
        wait_exchange(test, first_anim, last_anim);
        check_state(test, battle_pkg::fight_menu, fight_state);
        check_state(test, first, first_anim);
        check_state(test, (first == battle_pkg::fight_animation_p1) ?
                    battle_pkg::fight_animation_p2 : battle_pkg::fight_animation_p1, last_anim);
        check_skill(test, creature_pkg::skill_id_t'(k), p1_skill_id);
        if (!(p2_skill_id inside {[1:3]})) stop_run({test, ": opponent skill id is not 1 to 3"});
        check_hp(test, after_hit(hp2, d1[k]), p2_hp);
        check_hp(test, after_hit(hp1, d2[int'(p2_skill_id)]), p1_hp);
    endtask

    //////////////////////////////////////////////////
    // directed tests
    //////////////////////////////////////////////////
    initial begin
        battle_pkg::fight_state_t first_anim, last_anim;
        int cycles;
        reset = 1'b1;
        scene = battle_pkg::scene_fight;
        keys  = '0;
        randomize_creatures(8'd50, 8'd20);
        repeat (5) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);

        check_state("reset", battle_pkg::fight_menu, fight_state);
        check_option("reset", battle_pkg::option_1, option);
        check_skill("reset", 4'd1, p1_skill_id);
        check_skill("reset", 4'd1, p2_skill_id);
        check_hp("reset", p1_hp_init, p1_hp);
        check_hp("reset", p2_hp_init, p2_hp);
        if (to_end_scene !== 1'b0) stop_run("reset: to_end_scene is high after reset");

        // main menu, then the 2x2 skill grid
        press(battle_pkg::key_right);
        check_option("menu cursor", battle_pkg::option_2, option);
        press(battle_pkg::key_left);
        check_option("menu cursor", battle_pkg::option_1, option);
        press(battle_pkg::key_right | battle_pkg::key_confirm);
        check_option("two keys in menu", battle_pkg::option_1, option);
        check_state("two keys in menu", battle_pkg::fight_menu, fight_state);
        press(battle_pkg::key_confirm);
        check_state("skill cursor", battle_pkg::fight_choosing_skill, fight_state);
        press(battle_pkg::key_down);
        check_option("skill cursor", battle_pkg::option_3, option);
        press(battle_pkg::key_right);
        check_option("skill cursor", battle_pkg::option_4, option);
        press(battle_pkg::key_up);
        check_option("skill cursor", battle_pkg::option_2, option);
        press(battle_pkg::key_left);
        check_option("skill cursor", battle_pkg::option_1, option);
        press(battle_pkg::key_up | battle_pkg::key_right);
        check_option("two keys in skills", battle_pkg::option_1, option);
        press(battle_pkg::key_down);
        press(battle_pkg::key_right);
        press(battle_pkg::key_confirm);
        check_state("back", battle_pkg::fight_menu, fight_state);
        check_option("back", battle_pkg::option_1, option);

        reload;
        run_exchange("p1 faster", 2, battle_pkg::fight_animation_p1);
        randomize_creatures(8'd20, 8'd50);
        reload;
        run_exchange("p2 faster", 3, battle_pkg::fight_animation_p2);

        // equal speeds, so p1 strikes first and p2 knocks it out
        randomize_creatures(8'd40, 8'd40);
        p1_hp_init  = creature_pkg::hp_t'(20 + ($random(seed) & 31));
        p2_damage_1 = 8'd200;
        p2_damage_2 = 8'd210;
        p2_damage_3 = 8'd220;
        reload;
        press(battle_pkg::key_confirm);
        press(battle_pkg::key_confirm);
        wait_exchange("knockout", first_anim, last_anim);
        check_state("knockout", battle_pkg::fight_p2_win, fight_state);
        check_state("knockout", battle_pkg::fight_animation_p1, first_anim);
        check_hp("knockout", 8'd0, p1_hp);
        cycles = 0;
        while (!to_end_scene) begin
            if (cycles == 100) stop_run("knockout: to_end_scene never pulsed after the win");
            cycles++;
            @(negedge clk);
        end
        repeat (30) begin
            @(negedge clk);
            if (to_end_scene) stop_run("knockout: to_end_scene was high for more than one cycle");
        end

        // outside the fight scene the battle freezes, hp and the cursor hold
        scene = battle_pkg::scene_win;
        @(negedge clk);
        check_state("freeze", battle_pkg::fight_menu, fight_state);
        check_hp("freeze", 8'd0, p1_hp);
        scene = battle_pkg::scene_fight;
        press(battle_pkg::key_right);
        check_option("freeze", battle_pkg::option_2, option);
        scene = battle_pkg::scene_win;
        press(battle_pkg::key_left);
        check_option("freeze", battle_pkg::option_2, option);
        check_state("freeze", battle_pkg::fight_menu, fight_state);
        scene = battle_pkg::scene_fight;
        press(battle_pkg::key_confirm);
        check_state("flee", battle_pkg::fight_p2_win, fight_state);
        reload;
        check_hp("reload", p1_hp_init, p1_hp);
        check_hp("reload", p2_hp_init, p2_hp);
        check_state("reload", battle_pkg::fight_menu, fight_state);
        check_option("reload", battle_pkg::option_1, option);

        $display("RESULT: PASS");
        $finish;
    end

endmodule

//--- battle_control.f
verilog/battle_pkg.sv
verilog/creature_pkg.sv
verilog/interval_timer.sv
verilog/menu_cursor.sv
verilog/skill_select.sv
verilog/hp_drain.sv
verilog/turn_sequencer.sv
verilog/battle_control.sv
sim/tb_battle_control.sv

//--- Makefile
VERILATOR  ?= verilator
FILELIST   ?= battle_control.f
TB_TOP     ?= tb_battle_control
RTL_TOP    ?= battle_control
OBJ_DIR    ?= obj_dir
LINT_FLAGS ?= --lint-only -Wall --timing
SIM_FLAGS  ?= --binary --timing --assert -Wno-fatal
PASS_TEXT  ?= RESULT: PASS

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TB_TOP) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TB_TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
